/* run_sim.sh */
#!/usr/bin/env bash
# build and run the EX/MEM pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_ex_pipe -f verilog.f -o sim_ex_pipe \
	> build.log 2>&1 \
	&& ./obj_dir/sim_ex_pipe > sim.log 2>&1 \
	|| { cat build.log; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import rv_pkg::*; (
	input  data_t   src1,
	input  data_t   src2,
	input  alu_op_e alu_op,
	output data_t   result
);

	logic [4:0] shamt;

	// RV32I shifts only look at the low five bits
	assign shamt = src2[4:0];

	always_comb begin
		case (alu_op)
			alu_add:
				result = src1 + src2;
			alu_sub:
				result = src1 - src2;
			alu_sll:
				result = src1 << shamt;
			alu_slt:
				result = data_t'($signed(src1) < $signed(src2));
			alu_sltu:
				result = data_t'(src1 < src2);
			alu_xor:
				result = src1 ^ src2;
			alu_srl:
				result = src1 >> shamt;
			alu_sra:
				result = data_t'($signed(src1) >>> shamt);
			alu_or:
				result = src1 | src2;
			alu_and:
				result = src1 & src2;
			// lui puts the upper immediate straight through
			alu_pass_b:
				result = src2;
			default:
				result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit import rv_pkg::*; (
	input  logic       valid,
	input  bru_op_e    bru_op,
	input  data_t      rs1_val,
	input  data_t      rs2_val,
	input  data_t      pc,
	input  data_t      imm,
	input  logic       predicted,
	output branch_fb_t fb
);

	logic  cond;
	logic  is_branch;
	data_t base;
	data_t sum;
	data_t target;

	always_comb begin
		case (bru_op)
			bru_beq:  cond = (rs1_val == rs2_val);
			bru_bne:  cond = (rs1_val != rs2_val);
			bru_blt:  cond = ($signed(rs1_val) < $signed(rs2_val));
			bru_bge:  cond = ($signed(rs1_val) >= $signed(rs2_val));
			bru_bltu: cond = (rs1_val < rs2_val);
			bru_bgeu: cond = (rs1_val >= rs2_val);
			// jumps are unconditional
			bru_jal,
			bru_jalr: cond = 1'b1;
			default:  cond = 1'b0;
		endcase
	end

	assign is_branch = (bru_op != bru_none);

	// jalr is register relative, everything else pc relative
	assign base   = (bru_op == bru_jalr) ? rs1_val : pc;
	assign sum    = base + imm;
	assign target = (bru_op == bru_jalr) ? (sum & ~data_t'(1)) : sum;

	assign fb = '{
		valid:      valid,
		is_branch:  is_branch,
		taken:      cond,
		target:     target,
		pc:         pc,
		predicted:  predicted,
		mispredict: valid && is_branch && (cond != predicted)
	};

endmodule

`default_nettype wire

/* src/ex_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_top import rv_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  id_ex_t     id_ex,
	output wb_t        wb,
	output branch_fb_t branch_fb,
	output reg_idx_t   id_ex_rd,
	output logic       id_ex_mem_read
);

	ex_mem_t ex_mem;
	wb_t     mem_wb;

	// EX stage, sees both later stages for forwarding
	stage_ex u_stage_ex (
		.clk            (clk),
		.rst_n          (rst_n),
		.id_ex          (id_ex),
		.mem_wb         (mem_wb),
		.ex_mem         (ex_mem),
		.branch_fb      (branch_fb),
		.id_ex_rd       (id_ex_rd),
		.id_ex_mem_read (id_ex_mem_read)
	);

	mem_stage u_mem_stage (
		.clk    (clk),
		.rst_n  (rst_n),
		.ex_mem (ex_mem),
		.mem_wb (mem_wb)
	);

	// register file write port straight from MEM/WB
	assign wb = mem_wb;

endmodule

`default_nettype wire

/* src/forward_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module forward_unit import rv_pkg::*; (
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  ex_mem_t  ex_mem,
	input  wb_t      mem_wb,
	output fwd_sel_e fwd_a,
	output fwd_sel_e fwd_b
);

	logic ex_mem_hit_ok;
	logic mem_wb_hit_ok;

	// a stage may forward only if it really writes a nonzero register
	assign ex_mem_hit_ok = ex_mem.valid && ex_mem.wb_ctrl.reg_write && (ex_mem.rd != '0);
	assign mem_wb_hit_ok = mem_wb.valid && mem_wb.reg_write && (mem_wb.rd != '0);

	function automatic fwd_sel_e pick_source(
		input reg_idx_t rs,
		input logic     ex_ok,
		input reg_idx_t ex_rd,
		input logic     wb_ok,
		input reg_idx_t wb_rd
	);
		fwd_sel_e sel;
		sel = fwd_from_reg;
		// younger result takes priority
		if (ex_ok && (ex_rd == rs))
			sel = fwd_from_ex_mem;
		else if (wb_ok && (wb_rd == rs))
			sel = fwd_from_mem_wb;
		return sel;
	endfunction

	assign fwd_a = pick_source(rs1, ex_mem_hit_ok, ex_mem.rd, mem_wb_hit_ok, mem_wb.rd);
	assign fwd_b = pick_source(rs2, ex_mem_hit_ok, ex_mem.rd, mem_wb_hit_ok, mem_wb.rd);

endmodule

`default_nettype wire

/* src/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module mem_stage import rv_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  ex_mem_t ex_mem,
	output wb_t     mem_wb
);

	localparam int ADDR_LO = `RV_WORD_OFS_W;
	localparam int ADDR_HI = `RV_WORD_OFS_W + `RV_DMEM_ADDR_W - 1;

	data_t      dmem [`RV_DMEM_WORDS];
	dmem_addr_t addr;
	data_t      rd_word;
	logic       wr_en;

	// MEM/WB register
	logic       valid_q;
	logic       reg_write_q;
	reg_idx_t   rd_q;
	data_t      data_q;

	// word index from the byte address, upper bits ignored
	assign addr  = ex_mem.alu_result[ADDR_HI:ADDR_LO];
	assign wr_en = ex_mem.valid && ex_mem.mem_ctrl.mem_write;

	always_ff @(posedge clk) begin
		if (wr_en)
			dmem[addr] <= ex_mem.store_data;
	end

	// asynchronous read, result lands in MEM/WB
	assign rd_word = dmem[addr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q     <= 1'b0;
			reg_write_q <= 1'b0;
		end else begin
			valid_q     <= ex_mem.valid;
			reg_write_q <= ex_mem.valid && ex_mem.wb_ctrl.reg_write;
		end
	end

	always_ff @(posedge clk) begin
		rd_q <= ex_mem.rd;
		// loads return the RAM word, everything else the ALU result
		if (ex_mem.wb_ctrl.mem_to_reg)
			data_q <= rd_word;
		else
			data_q <= ex_mem.alu_result;
	end

	assign mem_wb = '{
		valid:     valid_q,
		reg_write: reg_write_q,
		rd:        rd_q,
		data:      data_q
	};

endmodule

`default_nettype wire

/* src/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath width of the integer core
`define RV_DATA_W 32

// register file index, x0..x31
`define RV_REG_IDX_W 5

// data RAM size in 32-bit words
`define RV_DMEM_WORDS 256

// word index into the data RAM, log2 of the depth
`define RV_DMEM_ADDR_W 8

// byte offset bits dropped from a word address
`define RV_WORD_OFS_W 2

`endif

/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

`include "rv_defines.svh"

	typedef logic [`RV_DATA_W-1:0] data_t;
	typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;
	typedef logic [`RV_DMEM_ADDR_W-1:0] dmem_addr_t;

	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_sll    = 4'd2,
		alu_slt    = 4'd3,
		alu_sltu   = 4'd4,
		alu_xor    = 4'd5,
		alu_srl    = 4'd6,
		alu_sra    = 4'd7,
		alu_or     = 4'd8,
		alu_and    = 4'd9,
		alu_pass_b = 4'd10
	} alu_op_e;

	// operand selection, bit 1 set means the first operand is pc
	typedef enum logic [1:0] {
		src_reg_reg  = 2'b00,
		src_reg_imm  = 2'b01,
		src_pc_plus4 = 2'b10,
		src_pc_imm   = 2'b11
	} alu_src_e;

	typedef enum logic [3:0] {
		bru_none = 4'd0,
		bru_beq  = 4'd1,
		bru_bne  = 4'd2,
		bru_blt  = 4'd3,
		bru_bge  = 4'd4,
		bru_bltu = 4'd5,
		bru_bgeu = 4'd6,
		bru_jal  = 4'd7,
		bru_jalr = 4'd8
	} bru_op_e;

	typedef enum logic [1:0] {
		fwd_from_reg    = 2'b00,
		fwd_from_mem_wb = 2'b01,
		fwd_from_ex_mem = 2'b10
	} fwd_sel_e;

	typedef struct packed {
		bru_op_e  bru_op;
		alu_op_e  alu_op;
		alu_src_e alu_src;
	} ex_ctrl_t;

	typedef struct packed {
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	// contents of the ID/EX register as handed over by decode
	typedef struct packed {
		logic      valid;
		ex_ctrl_t  ex_ctrl;
		mem_ctrl_t mem_ctrl;
		wb_ctrl_t  wb_ctrl;
		reg_idx_t  rs1;
		reg_idx_t  rs2;
		reg_idx_t  rd;
		data_t     reg_data1;
		data_t     reg_data2;
		data_t     imm;
		data_t     pc;
		logic      predict_taken;
	} id_ex_t;

	typedef struct packed {
		logic      valid;
		mem_ctrl_t mem_ctrl;
		wb_ctrl_t  wb_ctrl;
		reg_idx_t  rd;
		data_t     alu_result;
		data_t     store_data;
	} ex_mem_t;

	// MEM/WB register, also the register file write port
	typedef struct packed {
		logic     valid;
		logic     reg_write;
		reg_idx_t rd;
		data_t    data;
	} wb_t;

	typedef struct packed {
		logic  valid;
		logic  is_branch;
		logic  taken;
		data_t target;
		data_t pc;
		logic  predicted;
		logic  mispredict;
	} branch_fb_t;

endpackage

`default_nettype wire

/* src/stage_ex.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_ex import rv_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  id_ex_t     id_ex,
	input  wb_t        mem_wb,
	output ex_mem_t    ex_mem,
	output branch_fb_t branch_fb,
	output reg_idx_t   id_ex_rd,
	output logic       id_ex_mem_read
);

	fwd_sel_e  fwd_a;
	fwd_sel_e  fwd_b;
	data_t     rs1_fwd;
	data_t     rs2_fwd;
	data_t     src1;
	data_t     src2;
	data_t     alu_result;
	alu_src_e  alu_src;

	// EX/MEM register, control part
	logic      valid_q;
	mem_ctrl_t mem_ctrl_q;
	wb_ctrl_t  wb_ctrl_q;
	// EX/MEM register, payload part
	reg_idx_t  rd_q;
	data_t     alu_result_q;
	data_t     store_data_q;

	assign alu_src = id_ex.ex_ctrl.alu_src;

	// hazard info back to decode
	assign id_ex_rd       = id_ex.rd;
	assign id_ex_mem_read = id_ex.valid && id_ex.mem_ctrl.mem_read;

	forward_unit u_forward (
		.rs1    (id_ex.rs1),
		.rs2    (id_ex.rs2),
		.ex_mem (ex_mem),
		.mem_wb (mem_wb),
		.fwd_a  (fwd_a),
		.fwd_b  (fwd_b)
	);

	always_comb begin
		case (fwd_a)
			fwd_from_ex_mem: rs1_fwd = ex_mem.alu_result;
			fwd_from_mem_wb: rs1_fwd = mem_wb.data;
			default:         rs1_fwd = id_ex.reg_data1;
		endcase
	end

	always_comb begin
		case (fwd_b)
			fwd_from_ex_mem: rs2_fwd = ex_mem.alu_result;
			fwd_from_mem_wb: rs2_fwd = mem_wb.data;
			default:         rs2_fwd = id_ex.reg_data2;
		endcase
	end

	// pc replaces rs1 for link values and auipc
	assign src1 = alu_src[1] ? id_ex.pc : rs1_fwd;

	always_comb begin
		case (alu_src)
			src_reg_reg:  src2 = rs2_fwd;
			src_pc_plus4: src2 = data_t'(4);
			default:      src2 = id_ex.imm;
		endcase
	end

	alu u_alu (
		.src1   (src1),
		.src2   (src2),
		.alu_op (id_ex.ex_ctrl.alu_op),
		.result (alu_result)
	);

	branch_unit u_branch (
		.valid     (id_ex.valid),
		.bru_op    (id_ex.ex_ctrl.bru_op),
		.rs1_val   (rs1_fwd),
		.rs2_val   (rs2_fwd),
		.pc        (id_ex.pc),
		.imm       (id_ex.imm),
		.predicted (id_ex.predict_taken),
		.fb        (branch_fb)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q    <= 1'b0;
			mem_ctrl_q <= '0;
			wb_ctrl_q  <= '0;
		end else begin
			valid_q    <= id_ex.valid;
			mem_ctrl_q <= id_ex.mem_ctrl;
			wb_ctrl_q  <= id_ex.wb_ctrl;
		end
	end

	always_ff @(posedge clk) begin
		rd_q         <= id_ex.rd;
		alu_result_q <= alu_result;
		// store data is the forwarded rs2
		store_data_q <= rs2_fwd;
	end

	assign ex_mem = '{
		valid:      valid_q,
		mem_ctrl:   mem_ctrl_q,
		wb_ctrl:    wb_ctrl_q,
		rd:         rd_q,
		alu_result: alu_result_q,
		store_data: store_data_q
	};

endmodule

`default_nettype wire

/* verif/ex_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_checker import rv_pkg::*; (
	input  logic       clk,
	input  logic       active,
	input  logic       done,
	input  int         line_no,
	input  int         group,
	input  wb_t        wb,
	input  branch_fb_t branch_fb,
	input  reg_idx_t   id_ex_rd,
	input  logic       id_ex_mem_read,
	input  wb_t        exp_wb,
	input  logic       exp_valid,
	input  logic       exp_bchk,
	input  logic       exp_taken,
	input  data_t      exp_target,
	input  data_t      exp_pc,
	input  logic       exp_predicted,
	input  logic       exp_mispredict,
	input  logic       exp_mem_read,
	input  logic       exp_rd_chk,
	input  reg_idx_t   exp_rd,
	output int         checks,
	output int         errors
);

	int cur_group = -1;
	int grp_checks = 0;
	int grp_errors = 0;

	function automatic string group_name(input int g);
		case (g)
			1: return "alu ops";
			2: return "forwarding";
			3: return "store and load";
			4: return "branches";
			5: return "jumps and auipc";
			6: return "reset";
			default: return "other";
		endcase
	endfunction

	task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		grp_checks++;
		if (exp !== act) begin
			errors++;
			grp_errors++;
			$display("MISMATCH %s line %0d: expected %h, actual %h", name, line_no, exp, act);
		end
	endtask

	task automatic report_group();
		$display("group %0d (%s) done: %0d checks, %0d errors", cur_group,
			group_name(cur_group), grp_checks, grp_errors);
	endtask

	initial begin
		checks = 0;
		errors = 0;
	end

	// sample just before the rising edge, inputs settled since the falling edge
	always @(negedge clk) begin
		#4;
		if (active) begin
			if (group != cur_group) begin
				if (cur_group >= 0)
					report_group();
				cur_group = group;
				grp_checks = 0;
				grp_errors = 0;
			end
			check_field("wb.valid", 32'(exp_wb.valid), 32'(wb.valid));
			check_field("wb.reg_write", 32'(exp_wb.reg_write), 32'(wb.reg_write));
			if (exp_wb.valid) begin
				check_field("wb.rd", 32'(exp_wb.rd), 32'(wb.rd));
				check_field("wb.data", exp_wb.data, wb.data);
			end
			check_field("branch_fb.valid", 32'(exp_valid), 32'(branch_fb.valid));
			check_field("branch_fb.is_branch", 32'(exp_bchk), 32'(branch_fb.is_branch));
			if (exp_bchk) begin
				check_field("branch_fb.taken", 32'(exp_taken), 32'(branch_fb.taken));
				check_field("branch_fb.target", exp_target, branch_fb.target);
				check_field("branch_fb.pc", exp_pc, branch_fb.pc);
				check_field("branch_fb.predicted", 32'(exp_predicted),
					32'(branch_fb.predicted));
				check_field("branch_fb.mispredict", 32'(exp_mispredict),
					32'(branch_fb.mispredict));
			end
			check_field("id_ex_mem_read", 32'(exp_mem_read), 32'(id_ex_mem_read));
			if (exp_rd_chk)
				check_field("id_ex_rd", 32'(exp_rd), 32'(id_ex_rd));
		end
	end

	always @(posedge done) begin
		if (cur_group >= 0)
			report_group();
	end

endmodule

`default_nettype wire

/* verif/ex_trace.txt */
# grp v bru alu src mr mw rw m2r rs1 rs2 rd data1 data2 imm pc pt | then expected:
# wb_valid wb_rw wb_rd wb_data br_chk taken target mispredict id_ex_mem_read (all hex)
6 1 0 0 0 0 0 1 0 1e 1f 1 5 3 0 100 0 0 0 0 0 0 0 0 0 0
6 1 0 1 0 0 0 1 0 1e 1f 2 3 5 0 104 0 0 0 0 0 0 0 0 0 0
1 1 0 2 1 0 0 1 0 1e 1f 3 1 0 24 108 0 1 1 1 8 0 0 0 0 0
1 1 0 3 0 0 0 1 0 1e 1f 4 ffffffff 1 0 10c 0 1 1 2 fffffffe 0 0 0 0 0
1 1 0 4 0 0 0 1 0 1e 1f 5 ffffffff 1 0 110 0 1 1 3 10 0 0 0 0 0
1 1 0 5 1 0 0 1 0 1e 1f 6 f0f0f0f0 0 ffffffff 114 0 1 1 4 1 0 0 0 0 0
1 1 0 6 1 0 0 1 0 1e 1f 7 80000000 0 4 118 0 1 1 5 0 0 0 0 0 0
1 1 0 7 1 0 0 1 0 1e 1f 8 80000000 0 4 11c 0 1 1 6 f0f0f0f 0 0 0 0 0
1 1 0 8 0 0 0 1 0 1e 1f 9 12340000 5678 0 120 0 1 1 7 8000000 0 0 0 0 0
1 1 0 9 0 0 0 1 0 1e 1f 0 ffff0000 ff00ff0 0 124 0 1 1 8 f8000000 0 0 0 0 0
1 1 0 a 1 0 0 1 0 1e 1f a 0 0 abcde000 128 0 1 1 9 12345678 0 0 0 0 0
2 1 0 0 1 0 0 1 0 1e 1f b 64 0 1 12c 0 1 1 0 ff00000 0 0 0 0 0
2 1 0 0 0 0 0 1 0 b 1f c 0 2 0 130 0 1 1 a abcde000 0 0 0 0 0
2 1 0 0 0 0 0 1 0 b c d 0 0 0 134 0 1 1 b 65 0 0 0 0 0
2 1 0 0 1 0 0 1 0 1e 1f e 1 0 0 138 0 1 1 c 67 0 0 0 0 0
2 1 0 0 1 0 0 1 0 1e 1f e 2 0 0 13c 0 1 1 d cc 0 0 0 0 0
2 1 0 0 0 0 0 1 0 e e f 0 0 0 140 0 1 1 e 1 0 0 0 0 0
2 1 0 0 1 0 0 1 0 1e 1f 0 77 0 0 144 0 1 1 e 2 0 0 0 0 0
2 1 0 0 0 0 0 1 0 0 0 10 0 0 0 148 0 1 1 f 4 0 0 0 0 0
3 1 0 0 1 0 1 0 0 1e 1f 0 100 cafef00d 8 14c 0 1 1 0 77 0 0 0 0 0
3 1 0 0 1 1 0 1 1 1e 1f 11 100 0 8 150 0 1 1 10 0 0 0 0 0 1
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 108 0 0 0 0 0
3 1 0 0 1 0 0 1 0 11 1f 12 0 0 1 154 0 1 1 11 cafef00d 0 0 0 0 0
4 1 1 a 1 0 0 0 0 1e 1f 0 5 5 10 200 0 0 0 0 0 1 1 210 1 0
4 1 1 a 1 0 0 0 0 1e 1f 0 5 5 10 204 1 1 1 12 cafef00e 1 1 214 0 0
4 1 2 a 1 0 0 0 0 1e 1f 0 5 5 10 208 0 1 0 0 10 1 0 218 0 0
4 1 2 a 1 0 0 0 0 1e 1f 0 5 5 10 20c 1 1 0 0 10 1 0 21c 1 0
4 1 3 a 1 0 0 0 0 1e 1f 0 ffffffff 1 fffffff0 210 0 1 0 0 10 1 1 200 1 0
4 1 3 a 1 0 0 0 0 1e 1f 0 ffffffff 1 fffffff0 214 1 1 0 0 10 1 1 204 0 0
4 1 4 a 1 0 0 0 0 1e 1f 0 ffffffff 1 20 218 0 1 0 0 fffffff0 1 0 238 0 0
4 1 4 a 1 0 0 0 0 1e 1f 0 ffffffff 1 20 21c 1 1 0 0 fffffff0 1 0 23c 1 0
4 1 5 a 1 0 0 0 0 1e 1f 0 ffffffff 1 8 220 0 1 0 0 20 1 0 228 0 0
4 1 5 a 1 0 0 0 0 1e 1f 0 ffffffff 1 8 224 1 1 0 0 20 1 0 22c 1 0
4 1 6 a 1 0 0 0 0 1e 1f 0 ffffffff 1 8 228 0 1 0 0 8 1 1 230 1 0
4 1 6 a 1 0 0 0 0 1e 1f 0 ffffffff 1 8 22c 1 1 0 0 8 1 1 234 0 0
5 1 7 0 2 0 0 1 0 1e 1f 13 0 0 40 300 1 1 0 0 8 1 1 340 0 0
5 1 8 0 2 0 0 1 0 1e 1f 14 1001 0 6 304 0 1 0 0 8 1 1 1006 1 0
5 1 0 0 3 0 0 1 0 1e 1f 15 0 0 12345000 308 0 1 1 13 304 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 14 308 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 15 12345308 0 0 0 0 0

/* verif/tb_ex_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_pipe import rv_pkg::*; ();

	localparam int MAX_LINES = 128;
	localparam int N_COLS = 26;

	logic       clk;
	logic       rst_n;
	id_ex_t     id_ex;
	wb_t        wb;
	branch_fb_t branch_fb;
	reg_idx_t   id_ex_rd;
	logic       id_ex_mem_read;

	// expected values handed to the checker
	logic     active;
	logic     done;
	int       line_no;
	int       group;
	wb_t      exp_wb;
	logic     exp_valid;
	logic     exp_bchk;
	logic     exp_taken;
	data_t    exp_target;
	data_t    exp_pc;
	logic     exp_predicted;
	logic     exp_mispredict;
	logic     exp_mem_read;
	reg_idx_t exp_rd;
	int       checks;
	int       errors;

	logic [31:0] trace_mem [0:MAX_LINES-1][0:N_COLS-1];
	int n_lines = 0;
	logic bad_trace = 1'b0;
	int cycles = 0;
	int limit = 20;

	ex_pipe_top uut (
		.clk            (clk),
		.rst_n          (rst_n),
		.id_ex          (id_ex),
		.wb             (wb),
		.branch_fb      (branch_fb),
		.id_ex_rd       (id_ex_rd),
		.id_ex_mem_read (id_ex_mem_read)
	);

	ex_checker u_checker (
		.clk            (clk),
		.active         (active),
		.done           (done),
		.line_no        (line_no),
		.group          (group),
		.wb             (wb),
		.branch_fb      (branch_fb),
		.id_ex_rd       (id_ex_rd),
		.id_ex_mem_read (id_ex_mem_read),
		.exp_wb         (exp_wb),
		.exp_valid      (exp_valid),
		.exp_bchk       (exp_bchk),
		.exp_taken      (exp_taken),
		.exp_target     (exp_target),
		.exp_pc         (exp_pc),
		.exp_predicted  (exp_predicted),
		.exp_mispredict (exp_mispredict),
		.exp_mem_read   (exp_mem_read),
		.exp_rd_chk     (id_ex.valid),
		.exp_rd         (exp_rd),
		.checks         (checks),
		.errors         (errors)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic load_trace();
		int fd;
		int n;
		logic [8*256-1:0] line_buf;
		logic [31:0] f [0:N_COLS-1];
		fd = $fopen("verif/ex_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open trace file verif/ex_trace.txt");
			bad_trace = 1'b1;
		end else begin
			while ($fgets(line_buf, fd) != 0) begin
				n = $sscanf(line_buf,
					"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
					f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
					f[22], f[23], f[24], f[25]);
				// comment and blank lines scan to nothing
				if (n == N_COLS && n_lines < MAX_LINES) begin
					for (int c = 0; c < N_COLS; c++)
						trace_mem[n_lines][c] = f[c];
					n_lines++;
				end else if (n > 0) begin
					$display("malformed trace line after entry %0d", n_lines);
					bad_trace = 1'b1;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_line(input int i);
		id_ex.valid              = trace_mem[i][1][0];
		id_ex.ex_ctrl.bru_op     = bru_op_e'(trace_mem[i][2][3:0]);
		id_ex.ex_ctrl.alu_op     = alu_op_e'(trace_mem[i][3][3:0]);
		id_ex.ex_ctrl.alu_src    = alu_src_e'(trace_mem[i][4][1:0]);
		id_ex.mem_ctrl.mem_read  = trace_mem[i][5][0];
		id_ex.mem_ctrl.mem_write = trace_mem[i][6][0];
		id_ex.wb_ctrl.reg_write  = trace_mem[i][7][0];
		id_ex.wb_ctrl.mem_to_reg = trace_mem[i][8][0];
		id_ex.rs1                = trace_mem[i][9][4:0];
		id_ex.rs2                = trace_mem[i][10][4:0];
		id_ex.rd                 = trace_mem[i][11][4:0];
		id_ex.reg_data1          = trace_mem[i][12];
		id_ex.reg_data2          = trace_mem[i][13];
		id_ex.imm                = trace_mem[i][14];
		id_ex.pc                 = trace_mem[i][15];
		id_ex.predict_taken      = trace_mem[i][16][0];
		exp_wb.valid     = trace_mem[i][17][0];
		exp_wb.reg_write = trace_mem[i][18][0];
		exp_wb.rd        = trace_mem[i][19][4:0];
		exp_wb.data      = trace_mem[i][20];
		exp_valid        = trace_mem[i][1][0];
		exp_bchk         = trace_mem[i][21][0];
		exp_taken        = trace_mem[i][22][0];
		exp_target       = trace_mem[i][23];
		exp_pc           = trace_mem[i][15];
		exp_predicted    = trace_mem[i][16][0];
		exp_mispredict   = trace_mem[i][24][0];
		exp_mem_read     = trace_mem[i][25][0];
		exp_rd           = trace_mem[i][11][4:0];
		group            = int'(trace_mem[i][0]);
		line_no          = i;
	endtask

	initial begin
		rst_n = 1'b0;
		id_ex = '0;
		active = 1'b0;
		done = 1'b0;
		line_no = 0;
		group = 0;
		exp_wb = '0;
		exp_valid = 1'b0;
		exp_bchk = 1'b0;
		exp_taken = 1'b0;
		exp_target = '0;
		exp_pc = '0;
		exp_predicted = 1'b0;
		exp_mispredict = 1'b0;
		exp_mem_read = 1'b0;
		exp_rd = '0;
		load_trace();
		limit = n_lines + 20;
		if (bad_trace || n_lines == 0) begin
			$display("trace could not be used, no tests run");
			$display("STATUS: FAIL");
			$finish;
		end else begin
			repeat (2) @(posedge clk);
			for (int i = 0; i < n_lines; i++) begin
				@(negedge clk);
				rst_n = 1'b1;
				drive_line(i);
				active = 1'b1;
			end
			@(negedge clk);
			active = 1'b0;
			id_ex = '0;
			done = 1'b1;
			#1;
			$display("tests finished: %0d checks, %0d errors", checks, errors);
			if (errors == 0)
				$display("STATUS: PASS");
			else
				$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/rv_pkg.sv
src/forward_unit.sv
src/alu.sv
src/branch_unit.sv
src/stage_ex.sv
src/mem_stage.sv
src/ex_pipe_top.sv
verif/ex_checker.sv
verif/tb_ex_pipe.sv
